/* include/mem_ctrl_macros.svh */
`ifndef MEM_CTRL_MACROS_SVH
`define MEM_CTRL_MACROS_SVH

// ---------------------------------------------------------------------------
// Widths
// ---------------------------------------------------------------------------
// Word address, user data, stored codeword
`define MC_ADDR_W       14
`define MC_DATA_W       32
`define MC_CODE_W       39
// Hamming parity count, also the syndrome width
`define MC_PAR_W        6

// Highest legal word address, also the end of the init sweep
`define MC_LAST_ADDR    14'd12287

// ---------------------------------------------------------------------------
// Response codes
// ---------------------------------------------------------------------------
`define MC_RESP_OKAY    2'b00
`define MC_RESP_ECCERR  2'b01
`define MC_RESP_BUSY    2'b10
`define MC_RESP_SLVERR  2'b11

`endif

/* design/mem_ctrl_pkg.sv */
`include "mem_ctrl_macros.svh"

package mem_ctrl_pkg;

    typedef logic [`MC_ADDR_W-1:0] addr_t;
    typedef logic [`MC_DATA_W-1:0] data_t;
    typedef logic [`MC_CODE_W-1:0] code_t;
    typedef logic [`MC_PAR_W-1:0]  syndrome_t;
    typedef logic [1:0]            resp_t;

    // Init sweep FSM
    typedef enum logic
    {
        INIT_IDLE,
        INIT_FILL
    } init_state_t;

    // Parity k covers every position 1..38 whose index has bit k set.
    // Run over a word with zeroed parity slots it yields the parities,
    // run over a stored word it yields the syndrome
    function automatic syndrome_t hamming_syndrome(code_t cw);
        syndrome_t s;
        s = '0;
        for (int p = 1; p < `MC_CODE_W; p++)
        begin
            for (int k = 0; k < `MC_PAR_W; k++)
            begin
                if (p[k])
                    s[k] = s[k] ^ cw[p];
            end
        end
        return s;
    endfunction

endpackage

/* design/mem_ctrl_ifs.sv */
`timescale 1ns/1ns
`include "mem_ctrl_macros.svh"

// Accepted write or init fill word, decode stage to encoder
interface wr_req_if;
    logic                  valid;
    logic                  fill;
    logic [`MC_ADDR_W-1:0] addr;
    logic [`MC_DATA_W-1:0] data;

    modport src
    (
        output valid,
        output fill,
        output addr,
        output data
    );

    modport dst
    (
        input valid,
        input fill,
        input addr,
        input data
    );
endinterface

// Per-read ECC outcome, decoder to status register
interface ecc_result_if;
    logic                  valid;
    logic                  corrected;
    logic                  uncorrectable;
    logic [`MC_ADDR_W-1:0] addr;

    modport src
    (
        output valid,
        output corrected,
        output uncorrectable,
        output addr
    );

    modport dst
    (
        input valid,
        input corrected,
        input uncorrectable,
        input addr
    );
endinterface

/* design/mem_req_decode.sv */
`timescale 1ns/1ns
`include "mem_ctrl_macros.svh"

module mem_req_decode
    import mem_ctrl_pkg::*;
(
    input  logic  MEM_ctrl_clk,
    input  logic  MEM_ctrl_rstn,
    input  logic  i_mem_init,
    input  logic  i_wr_en,
    input  addr_t i_wr_addr,
    input  data_t i_wr_data,
    input  logic  i_rd_en,
    input  addr_t i_rd_addr,
    output resp_t o_wr_resp,
    output logic  o_busy,
    output logic  o_init_done,
    output logic  o_rd_issue,
    output addr_t o_rd_addr,
    output resp_t o_rd_resp,
    output logic  o_bram_rd_en,
    wr_req_if.src wr_req
);

    logic        init_q;
    logic        wr_en_q;
    logic        rd_en_q;
    addr_t       wr_addr_q;
    data_t       wr_data_q;
    addr_t       rd_addr_q;
    init_state_t state;
    addr_t       fill_cnt;
    resp_t       wr_resp_nxt;
    resp_t       rd_resp_nxt;
    logic        fill_go;
    logic        wr_go;

    // ---------------------------------------------------------------------------
    // Request sampling
    // ---------------------------------------------------------------------------
    always_ff @(posedge MEM_ctrl_clk or negedge MEM_ctrl_rstn)
    begin
        if (!MEM_ctrl_rstn)
        begin
            init_q  <= 1'b0;
            wr_en_q <= 1'b0;
            rd_en_q <= 1'b0;
        end
        else
        begin
            init_q  <= i_mem_init;
            wr_en_q <= i_wr_en;
            rd_en_q <= i_rd_en;
        end
    end

    always_ff @(posedge MEM_ctrl_clk)
    begin
        wr_addr_q <= i_wr_addr;
        wr_data_q <= i_wr_data;
        rd_addr_q <= i_rd_addr;
    end

    // Busy refusal comes before the range check
    always_comb
    begin
        if (o_busy)
            wr_resp_nxt = `MC_RESP_BUSY;
        else if (wr_addr_q > `MC_LAST_ADDR)
            wr_resp_nxt = `MC_RESP_SLVERR;
        else
            wr_resp_nxt = `MC_RESP_OKAY;

        if (o_busy)
            rd_resp_nxt = `MC_RESP_BUSY;
        else if (rd_addr_q > `MC_LAST_ADDR)
            rd_resp_nxt = `MC_RESP_SLVERR;
        else
            rd_resp_nxt = `MC_RESP_OKAY;
    end

    assign fill_go = (state == INIT_FILL);
    assign wr_go   = wr_en_q && (wr_resp_nxt == `MC_RESP_OKAY);

    // ---------------------------------------------------------------------------
    // Init sweep, one zero word per cycle over 0 .. MC_LAST_ADDR
    // ---------------------------------------------------------------------------
    always_ff @(posedge MEM_ctrl_clk or negedge MEM_ctrl_rstn)
    begin
        if (!MEM_ctrl_rstn)
        begin
            state       <= INIT_IDLE;
            fill_cnt    <= '0;
            o_busy      <= 1'b0;
            o_init_done <= 1'b0;
        end
        else
        begin
            o_init_done <= 1'b0;
            case (state)
                INIT_IDLE:
                begin
                    if (init_q)
                    begin
                        state    <= INIT_FILL;
                        fill_cnt <= '0;
                        o_busy   <= 1'b1;
                    end
                end
                INIT_FILL:
                begin
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_cnt == `MC_LAST_ADDR)
                    begin
                        state       <= INIT_IDLE;
                        o_busy      <= 1'b0;
                        o_init_done <= 1'b1;
                    end
                end
                default: state <= INIT_IDLE;
            endcase
        end
    end

    // ---------------------------------------------------------------------------
    // Write path to the encoder and issued responses
    // ---------------------------------------------------------------------------
    always_ff @(posedge MEM_ctrl_clk or negedge MEM_ctrl_rstn)
    begin
        if (!MEM_ctrl_rstn)
        begin
            wr_req.valid <= 1'b0;
            wr_req.fill  <= 1'b0;
            o_wr_resp    <= `MC_RESP_OKAY;
            o_rd_issue   <= 1'b0;
            o_rd_resp    <= `MC_RESP_OKAY;
            o_bram_rd_en <= 1'b0;
        end
        else
        begin
            wr_req.valid <= fill_go || wr_go;
            wr_req.fill  <= fill_go;
            // Held until the next write
            if (wr_en_q)
                o_wr_resp <= wr_resp_nxt;
            o_rd_issue   <= rd_en_q;
            o_rd_resp    <= rd_en_q ? rd_resp_nxt : `MC_RESP_OKAY;
            o_bram_rd_en <= rd_en_q && (rd_resp_nxt == `MC_RESP_OKAY);
        end
    end

    always_ff @(posedge MEM_ctrl_clk)
    begin
        if (fill_go)
            wr_req.addr <= fill_cnt;
        else if (wr_go)
            wr_req.addr <= wr_addr_q;
        wr_req.data <= wr_data_q;
        if (rd_en_q)
            o_rd_addr <= rd_addr_q;
    end

    // Busy flag and sweep state must move together so no user write slips in
    a_no_fill_collision : assert property (
        @(posedge MEM_ctrl_clk) disable iff (!MEM_ctrl_rstn)
        !(fill_go && wr_go)
    );

endmodule

/* design/ecc_encoder.sv */
`timescale 1ns/1ns
`include "mem_ctrl_macros.svh"

module ecc_encoder
    import mem_ctrl_pkg::*;
(
    input  logic  MEM_ctrl_clk,
    input  logic  MEM_ctrl_rstn,
    input  logic  i_ecc_en,
    wr_req_if.dst wr_req,
    output logic  o_bram_wr_en,
    output addr_t o_bram_wr_addr,
    output code_t o_bram_wr_data
);

    data_t     enc_data;
    code_t     enc_word;
    syndrome_t enc_par;

    // Data bits go to the non power of two positions in ascending order
    function automatic code_t place_data(data_t d);
        code_t cw;
        int    j;
        cw = '0;
        j  = 0;
        for (int p = 1; p < `MC_CODE_W; p++)
        begin
            if ((p & (p - 1)) != 0)
            begin
                cw[p] = d[j];
                j++;
            end
        end
        return cw;
    endfunction

    always_comb
    begin
        // Fill words encode zero data
        enc_data = wr_req.fill ? '0 : wr_req.data;
        enc_word = place_data(enc_data);
        enc_par  = hamming_syndrome(enc_word);
        if (i_ecc_en)
        begin
            for (int k = 0; k < `MC_PAR_W; k++)
            begin
                enc_word[1 << k] = enc_par[k];
            end
            // Overall even parity across bits 1..38
            enc_word[0] = ^enc_word[`MC_CODE_W-1:1];
        end
    end

    always_ff @(posedge MEM_ctrl_clk or negedge MEM_ctrl_rstn)
    begin
        if (!MEM_ctrl_rstn)
            o_bram_wr_en <= 1'b0;
        else
            o_bram_wr_en <= wr_req.valid;
    end

    always_ff @(posedge MEM_ctrl_clk)
    begin
        if (wr_req.valid)
        begin
            o_bram_wr_addr <= wr_req.addr;
            o_bram_wr_data <= enc_word;
        end
    end

endmodule

/* design/ecc_decoder.sv */
`timescale 1ns/1ns
`include "mem_ctrl_macros.svh"

module ecc_decoder
    import mem_ctrl_pkg::*;
(
    input  logic      MEM_ctrl_clk,
    input  logic      MEM_ctrl_rstn,
    input  logic      i_ecc_en,
    input  logic      i_rd_issue,
    input  addr_t     i_rd_addr,
    input  resp_t     i_rd_resp,
    input  code_t     i_bram_rd_data,
    output logic      o_rd_valid,
    output data_t     o_rd_data,
    output resp_t     o_rd_resp,
    ecc_result_if.src result
);

    logic      tag_valid;
    resp_t     tag_resp;
    addr_t     tag_addr;
    logic      tag_ok;
    logic      ecc_chk;
    syndrome_t syndrome;
    logic      par_err;
    logic      dbl_err;
    code_t     fixed_word;
    data_t     rd_word;

    function automatic data_t extract_data(code_t cw);
        data_t d;
        int    j;
        d = '0;
        j = 0;
        for (int p = 1; p < `MC_CODE_W; p++)
        begin
            if ((p & (p - 1)) != 0)
            begin
                d[j] = cw[p];
                j++;
            end
        end
        return d;
    endfunction

    // ---------------------------------------------------------------------------
    // Tag stage, lines the issued read up with the registered BRAM data
    // ---------------------------------------------------------------------------
    always_ff @(posedge MEM_ctrl_clk or negedge MEM_ctrl_rstn)
    begin
        if (!MEM_ctrl_rstn)
        begin
            tag_valid <= 1'b0;
            tag_resp  <= `MC_RESP_OKAY;
        end
        else
        begin
            tag_valid <= i_rd_issue;
            tag_resp  <= i_rd_resp;
        end
    end

    always_ff @(posedge MEM_ctrl_clk)
    begin
        tag_addr <= i_rd_addr;
    end

    assign tag_ok  = tag_valid && (tag_resp == `MC_RESP_OKAY);
    assign ecc_chk = tag_ok && i_ecc_en;

    // Syndrome, overall parity and single-bit repair
    always_comb
    begin
        syndrome   = hamming_syndrome(i_bram_rd_data);
        par_err    = ^i_bram_rd_data;
        dbl_err    = (syndrome != '0) && !par_err;
        fixed_word = i_bram_rd_data;
        // Syndrome zero with bad parity means bit 0 itself flipped
        if (i_ecc_en && par_err && (syndrome < `MC_CODE_W))
            fixed_word[syndrome] = ~fixed_word[syndrome];
        rd_word = extract_data(fixed_word);
    end

    // ---------------------------------------------------------------------------
    // Read response and result report
    // ---------------------------------------------------------------------------
    always_ff @(posedge MEM_ctrl_clk or negedge MEM_ctrl_rstn)
    begin
        if (!MEM_ctrl_rstn)
        begin
            o_rd_valid           <= 1'b0;
            o_rd_resp            <= `MC_RESP_OKAY;
            result.valid         <= 1'b0;
            result.corrected     <= 1'b0;
            result.uncorrectable <= 1'b0;
        end
        else
        begin
            o_rd_valid <= tag_valid;
            if (!tag_valid)
                o_rd_resp <= `MC_RESP_OKAY;
            else if (tag_resp != `MC_RESP_OKAY)
                o_rd_resp <= tag_resp;
            else if (ecc_chk && dbl_err)
                o_rd_resp <= `MC_RESP_ECCERR;
            else
                o_rd_resp <= `MC_RESP_OKAY;
            result.valid         <= ecc_chk;
            result.corrected     <= ecc_chk && par_err;
            result.uncorrectable <= ecc_chk && dbl_err;
        end
    end

    always_ff @(posedge MEM_ctrl_clk)
    begin
        o_rd_data <= tag_ok ? rd_word : '0;
        if (ecc_chk)
            result.addr <= tag_addr;
    end

    // BRAM must deliver defined data one cycle after an enabled read
    a_rd_data_known : assert property (
        @(posedge MEM_ctrl_clk) disable iff (!MEM_ctrl_rstn)
        tag_ok |-> !$isunknown(i_bram_rd_data)
    );

endmodule

/* design/ecc_status.sv */
`timescale 1ns/1ns

module ecc_status
    import mem_ctrl_pkg::*;
(
    input  logic       MEM_ctrl_clk,
    input  logic       MEM_ctrl_rstn,
    input  logic       i_status_clear,
    input  logic       i_irq_en,
    ecc_result_if.dst  result,
    output logic [1:0] o_ecc_status,
    output addr_t      o_err_addr,
    output logic       o_ecc_irq
);

    // Bit 0 corrected, bit 1 uncorrectable, both sticky until cleared
    always_ff @(posedge MEM_ctrl_clk or negedge MEM_ctrl_rstn)
    begin
        if (!MEM_ctrl_rstn)
            o_ecc_status <= 2'b00;
        else if (i_status_clear)
            o_ecc_status <= 2'b00;
        else if (result.valid)
            o_ecc_status <= o_ecc_status | {result.uncorrectable, result.corrected};
    end

    // Latest failing read wins
    always_ff @(posedge MEM_ctrl_clk)
    begin
        if (result.valid && (result.corrected || result.uncorrectable))
            o_err_addr <= result.addr;
    end

    assign o_ecc_irq = i_irq_en && (o_ecc_status != 2'b00);

    // A recorded error only goes away through a clear
    a_status_sticky : assert property (
        @(posedge MEM_ctrl_clk) disable iff (!MEM_ctrl_rstn)
        ((o_ecc_status != 2'b00) && !i_status_clear) |=> (o_ecc_status != 2'b00)
    );

endmodule

/* design/mem_ctrl_top.sv */
`timescale 1ns/1ns

module mem_ctrl_top
    import mem_ctrl_pkg::*;
(
    input  logic       MEM_ctrl_clk,
    input  logic       MEM_ctrl_rstn,
    // User requests
    input  logic       i_mem_init,
    input  logic       i_wr_en,
    input  addr_t      i_wr_addr,
    input  data_t      i_wr_data,
    input  logic       i_rd_en,
    input  addr_t      i_rd_addr,
    // ECC control
    input  logic       i_ecc_en,
    input  logic       i_irq_en,
    input  logic       i_status_clear,
    input  code_t      i_bram_rd_data,
    output resp_t      o_wr_resp,
    output logic       o_rd_valid,
    output data_t      o_rd_data,
    output resp_t      o_rd_resp,
    output logic       o_busy,
    output logic       o_init_done,
    // BRAM ports
    output logic       o_bram_wr_en,
    output addr_t      o_bram_wr_addr,
    output code_t      o_bram_wr_data,
    output logic       o_bram_rd_en,
    output addr_t      o_bram_rd_addr,
    // Status
    output logic [1:0] o_ecc_status,
    output addr_t      o_err_addr,
    output logic       o_ecc_irq
);

    logic  rd_issue;
    resp_t rd_issue_resp;

    wr_req_if     u_wr_req ();
    ecc_result_if u_result ();

    mem_req_decode u_decode (
        .MEM_ctrl_clk   (MEM_ctrl_clk),
        .MEM_ctrl_rstn  (MEM_ctrl_rstn),
        .i_mem_init     (i_mem_init),
        .i_wr_en        (i_wr_en),
        .i_wr_addr      (i_wr_addr),
        .i_wr_data      (i_wr_data),
        .i_rd_en        (i_rd_en),
        .i_rd_addr      (i_rd_addr),
        .o_wr_resp      (o_wr_resp),
        .o_busy         (o_busy),
        .o_init_done    (o_init_done),
        .o_rd_issue     (rd_issue),
        .o_rd_addr      (o_bram_rd_addr),
        .o_rd_resp      (rd_issue_resp),
        .o_bram_rd_en   (o_bram_rd_en),
        .wr_req         (u_wr_req.src)
    );

    ecc_encoder u_encoder (
        .MEM_ctrl_clk   (MEM_ctrl_clk),
        .MEM_ctrl_rstn  (MEM_ctrl_rstn),
        .i_ecc_en       (i_ecc_en),
        .wr_req         (u_wr_req.dst),
        .o_bram_wr_en   (o_bram_wr_en),
        .o_bram_wr_addr (o_bram_wr_addr),
        .o_bram_wr_data (o_bram_wr_data)
    );

    ecc_decoder u_decoder (
        .MEM_ctrl_clk   (MEM_ctrl_clk),
        .MEM_ctrl_rstn  (MEM_ctrl_rstn),
        .i_ecc_en       (i_ecc_en),
        .i_rd_issue     (rd_issue),
        .i_rd_addr      (o_bram_rd_addr),
        .i_rd_resp      (rd_issue_resp),
        .i_bram_rd_data (i_bram_rd_data),
        .o_rd_valid     (o_rd_valid),
        .o_rd_data      (o_rd_data),
        .o_rd_resp      (o_rd_resp),
        .result         (u_result.src)
    );

    ecc_status u_status (
        .MEM_ctrl_clk   (MEM_ctrl_clk),
        .MEM_ctrl_rstn  (MEM_ctrl_rstn),
        .i_status_clear (i_status_clear),
        .i_irq_en       (i_irq_en),
        .result         (u_result.dst),
        .o_ecc_status   (o_ecc_status),
        .o_err_addr     (o_err_addr),
        .o_ecc_irq      (o_ecc_irq)
    );

endmodule

/* verif/tb_mem_ctrl.sv */
`timescale 1ns/1ns
`include "mem_ctrl_macros.svh"

module tb_mem_ctrl
    import mem_ctrl_pkg::*;
();

    localparam logic [1:0] OP_WR  = 2'd0;
    localparam logic [1:0] OP_RD  = 2'd1;
    localparam logic [1:0] OP_IRQ = 2'd2;
    localparam logic [1:0] OP_CLR = 2'd3;

    // One stimulus step with its expected outcome
    typedef struct packed
    {
        logic [1:0] op;
        addr_t      addr;
        data_t      data;
        logic       ecc;
        code_t      flip;
        resp_t      exp_resp;
        data_t      exp_data;
        logic [1:0] exp_status;
    } row_t;

    logic       MEM_ctrl_clk;
    logic       MEM_ctrl_rstn;
    logic       i_mem_init;
    logic       i_wr_en;
    addr_t      i_wr_addr;
    data_t      i_wr_data;
    logic       i_rd_en;
    addr_t      i_rd_addr;
    logic       i_ecc_en;
    logic       i_irq_en;
    logic       i_status_clear;
    code_t      i_bram_rd_data = '0;
    resp_t      o_wr_resp;
    logic       o_rd_valid;
    data_t      o_rd_data;
    resp_t      o_rd_resp;
    logic       o_busy;
    logic       o_init_done;
    logic       o_bram_wr_en;
    addr_t      o_bram_wr_addr;
    code_t      o_bram_wr_data;
    logic       o_bram_rd_en;
    addr_t      o_bram_rd_addr;
    logic [1:0] o_ecc_status;
    addr_t      o_err_addr;
    logic       o_ecc_irq;

    code_t bram [0:16383];
    code_t flip_mask;
    int    wr_count = 0;
    int    rd_count = 0;
    int    sweep_bad = 0;
    logic  sweep_on;
    int    sweep_base;
    int    seed;
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    test_err_start;
    row_t  rows[$];
    addr_t adr[5];
    data_t dat[5];

    mem_ctrl_top i_dut (
        .MEM_ctrl_clk   (MEM_ctrl_clk),
        .MEM_ctrl_rstn  (MEM_ctrl_rstn),
        .i_mem_init     (i_mem_init),
        .i_wr_en        (i_wr_en),
        .i_wr_addr      (i_wr_addr),
        .i_wr_data      (i_wr_data),
        .i_rd_en        (i_rd_en),
        .i_rd_addr      (i_rd_addr),
        .i_ecc_en       (i_ecc_en),
        .i_irq_en       (i_irq_en),
        .i_status_clear (i_status_clear),
        .i_bram_rd_data (i_bram_rd_data),
        .o_wr_resp      (o_wr_resp),
        .o_rd_valid     (o_rd_valid),
        .o_rd_data      (o_rd_data),
        .o_rd_resp      (o_rd_resp),
        .o_busy         (o_busy),
        .o_init_done    (o_init_done),
        .o_bram_wr_en   (o_bram_wr_en),
        .o_bram_wr_addr (o_bram_wr_addr),
        .o_bram_wr_data (o_bram_wr_data),
        .o_bram_rd_en   (o_bram_rd_en),
        .o_bram_rd_addr (o_bram_rd_addr),
        .o_ecc_status   (o_ecc_status),
        .o_err_addr     (o_err_addr),
        .o_ecc_irq      (o_ecc_irq)
    );

    initial
    begin
        MEM_ctrl_clk = 1'b0;
        forever #50 MEM_ctrl_clk = ~MEM_ctrl_clk;
    end

    // --------------------------------------------------------------------------
    // BRAM model with registered read data and bit-flip injection
    // --------------------------------------------------------------------------
    always @(posedge MEM_ctrl_clk)
    begin
        if (o_bram_wr_en)
        begin
            bram[o_bram_wr_addr] <= o_bram_wr_data;
            wr_count <= wr_count + 1;
            // Fill words must be zero and ascend from address 0
            if (sweep_on && (int'(o_bram_wr_addr) != wr_count - sweep_base
                || o_bram_wr_data != '0))
                sweep_bad <= sweep_bad + 1;
        end
        if (o_bram_rd_en)
        begin
            i_bram_rd_data <= bram[o_bram_rd_addr] ^ flip_mask;
            rd_count <= rd_count + 1;
        end
    end

    // Data takes the non power of two slots 1..38 in ascending order.
    // Parity k covers the slots whose index has bit k set, slot 0 evens the word
    function automatic code_t ref_encode(input data_t d, input logic ecc);
        code_t cw;
        int    next_bit;
        cw = '0;
        next_bit = 0;
        for (int pos = 1; pos <= 38; pos++)
        begin
            if ($countones(pos) != 1)
            begin
                cw[pos] = d[next_bit];
                next_bit++;
            end
        end
        if (ecc)
        begin
            for (int pos = 3; pos <= 38; pos++)
            begin
                for (int k = 0; k < 6; k++)
                begin
                    if ((((pos >> k) & 1) == 1) && ($countones(pos) != 1))
                        cw[1 << k] = cw[1 << k] ^ cw[pos];
                end
            end
            cw[0] = ^cw;
        end
        return cw;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_err_start)
        begin
            tests_failed++;
            $display("Test %0d %s FAILED, %0d errors", tests_run, name,
                     errors - test_err_start);
        end
        else
            $display("Test %0d %s passed", tests_run, name);
        test_err_start = errors;
    endtask

    // Counts rising edges from the request edge until the read response shows
    task automatic wait_read(output int lat);
        lat = 0;
        do
        begin
            @(posedge MEM_ctrl_clk);
            lat++;
            @(negedge MEM_ctrl_clk);
        end
        while (!o_rd_valid && lat < 10);
        if (!o_rd_valid)
        begin
            $display("Read response never arrived, time %0t ns", $time);
            errors++;
        end
    endtask

    task automatic run_init_sweep();
        int n;
        int lat;
        int rd0;
        sweep_base = wr_count;
        sweep_on = 1'b1;
        @(posedge MEM_ctrl_clk);
        i_mem_init <= 1'b1;
        @(posedge MEM_ctrl_clk);
        i_mem_init <= 1'b0;
        n = 0;
        do
        begin
            @(negedge MEM_ctrl_clk);
            n++;
        end
        while (!o_busy && n < 10);
        if (!o_busy)
        begin
            $display("o_busy did not rise after i_mem_init, time %0t ns", $time);
            errors++;
        end
        // A user write and read during the sweep are refused
        @(posedge MEM_ctrl_clk);
        i_wr_en <= 1'b1;
        i_wr_addr <= 14'd7;
        i_wr_data <= dat[0];
        i_rd_en <= 1'b1;
        i_rd_addr <= 14'd7;
        rd0 = rd_count;
        @(posedge MEM_ctrl_clk);
        i_wr_en <= 1'b0;
        i_rd_en <= 1'b0;
        wait_read(lat);
        check("o_wr_resp", o_wr_resp, `MC_RESP_BUSY);
        check("o_rd_resp", o_rd_resp, `MC_RESP_BUSY);
        check("o_rd_data", o_rd_data, '0);
        check("o_bram_rd_en count", rd_count - rd0, 0);
        n = 0;
        do
        begin
            @(negedge MEM_ctrl_clk);
            n++;
        end
        while (!o_init_done && n < 13000);
        if (!o_init_done)
        begin
            $display("o_init_done never pulsed during the sweep, time %0t ns", $time);
            errors++;
        end
        @(negedge MEM_ctrl_clk);
        check("o_init_done", o_init_done, 0);
        check("o_busy", o_busy, 0);
        repeat (3) @(negedge MEM_ctrl_clk);
        check("fill write count", wr_count - sweep_base, int'(`MC_LAST_ADDR) + 1);
        check("fill order or value faults", sweep_bad, 0);
        sweep_on = 1'b0;
    endtask

    task automatic add_row(input logic [1:0] op, input addr_t addr, input data_t data,
                           input logic ecc, input code_t flip, input resp_t exp_resp,
                           input data_t exp_data, input logic [1:0] exp_status);
        rows.push_back(row_t'{op, addr, data, ecc, flip, exp_resp, exp_data, exp_status});
    endtask

    task automatic apply_row(input row_t r);
        int cnt0;
        int lat;
        int exp_en;
        cnt0 = (r.op == OP_WR) ? wr_count : rd_count;
        exp_en = (r.addr <= `MC_LAST_ADDR) ? 1 : 0;
        @(posedge MEM_ctrl_clk);
        i_ecc_en <= r.ecc;
        flip_mask <= r.flip;
        case (r.op)
            OP_WR:
            begin
                i_wr_en <= 1'b1;
                i_wr_addr <= r.addr;
                i_wr_data <= r.data;
            end
            OP_RD:
            begin
                i_rd_en <= 1'b1;
                i_rd_addr <= r.addr;
            end
            OP_IRQ: i_irq_en <= r.data[0];
            default: i_status_clear <= 1'b1;
        endcase
        @(posedge MEM_ctrl_clk);
        i_wr_en <= 1'b0;
        i_rd_en <= 1'b0;
        i_status_clear <= 1'b0;
        if (r.op == OP_RD)
        begin
            wait_read(lat);
            check("read latency", lat, 3);
            check("o_rd_resp", o_rd_resp, r.exp_resp);
            check("o_rd_data", o_rd_data, r.exp_data);
            check("o_bram_rd_en count", rd_count - cnt0, exp_en);
            // Status settles one edge after the read response
            @(posedge MEM_ctrl_clk);
            @(negedge MEM_ctrl_clk);
        end
        else if (r.op == OP_WR)
        begin
            repeat (3) @(posedge MEM_ctrl_clk);
            @(negedge MEM_ctrl_clk);
            check("o_wr_resp", o_wr_resp, r.exp_resp);
            check("o_bram_wr_en count", wr_count - cnt0, exp_en);
            if (exp_en == 1)
                check("o_bram_wr_data", bram[r.addr], ref_encode(r.data, r.ecc));
        end
        else
            @(negedge MEM_ctrl_clk);
        check("o_ecc_status", o_ecc_status, r.exp_status);
        if (r.op == OP_IRQ)
            check("o_ecc_irq", o_ecc_irq, r.exp_data[0]);
        if (r.op == OP_RD && r.ecc && r.flip != '0)
            check("o_err_addr", o_err_addr, r.addr);
    endtask

    task automatic run_rows();
        foreach (rows[i])
            apply_row(rows[i]);
        rows.delete();
    endtask

    // Reads on four consecutive edges, each answered three edges later
    task automatic read_burst();
        @(posedge MEM_ctrl_clk);
        i_ecc_en <= 1'b1;
        flip_mask <= '0;
        i_rd_en <= 1'b1;
        i_rd_addr <= adr[0];
        for (int c = 0; c < 8; c++)
        begin
            @(posedge MEM_ctrl_clk);
            if (c < 3)
                i_rd_addr <= adr[c + 1];
            else
                i_rd_en <= 1'b0;
            @(negedge MEM_ctrl_clk);
            check("o_rd_valid", o_rd_valid, (c >= 3 && c < 7) ? 1 : 0);
            if (c >= 3 && c < 7)
            begin
                check("o_rd_resp", o_rd_resp, `MC_RESP_OKAY);
                check("o_rd_data", o_rd_data, dat[c - 3]);
            end
        end
    endtask

    // --------------------------------------------------------------------------
    // Test sequence
    // --------------------------------------------------------------------------
    initial
    begin
        seed = 32'h69b;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_err_start = 0;
        sweep_on = 1'b0;
        sweep_base = 0;
        flip_mask = '0;
        MEM_ctrl_rstn = 1'b0;
        i_mem_init = 1'b0;
        i_wr_en = 1'b0;
        i_wr_addr = '0;
        i_wr_data = '0;
        i_rd_en = 1'b0;
        i_rd_addr = '0;
        i_ecc_en = 1'b1;
        i_irq_en = 1'b0;
        i_status_clear = 1'b0;
        for (int i = 0; i < 5; i++)
            dat[i] = $random(seed);
        adr[0] = 14'h0010;
        adr[1] = 14'h1234;
        adr[2] = `MC_LAST_ADDR;
        adr[3] = 14'd5;
        adr[4] = 14'd100;

        repeat (10) @(posedge MEM_ctrl_clk);
        MEM_ctrl_rstn <= 1'b1;
        @(negedge MEM_ctrl_clk);
        check("o_bram_wr_en", o_bram_wr_en, 0);
        check("o_bram_rd_en", o_bram_rd_en, 0);
        check("o_wr_resp", o_wr_resp, 0);
        check("o_rd_valid", o_rd_valid, 0);
        check("o_rd_resp", o_rd_resp, 0);
        check("o_init_done", o_init_done, 0);
        check("o_busy", o_busy, 0);
        check("o_ecc_status", o_ecc_status, 0);
        check("o_ecc_irq", o_ecc_irq, 0);
        finish_test("reset state");

        run_init_sweep();
        finish_test("init sweep");

        for (int i = 0; i < 4; i++)
            add_row(OP_WR, adr[i], dat[i], 1'b1, '0, `MC_RESP_OKAY, '0, 2'b00);
        for (int i = 0; i < 4; i++)
            add_row(OP_RD, adr[i], '0, 1'b1, '0, `MC_RESP_OKAY, dat[i], 2'b00);
        run_rows();
        read_burst();
        finish_test("write and read back");

        add_row(OP_WR, `MC_LAST_ADDR + 14'd1, dat[4], 1'b1, '0, `MC_RESP_SLVERR, '0, 2'b00);
        add_row(OP_RD, `MC_LAST_ADDR + 14'd1, '0, 1'b1, '0, `MC_RESP_SLVERR, '0, 2'b00);
        add_row(OP_RD, 14'h3fff, '0, 1'b1, '0, `MC_RESP_SLVERR, '0, 2'b00);
        run_rows();
        finish_test("address errors");

        // Position 17 holds a data bit
        add_row(OP_RD, adr[1], '0, 1'b1, 39'h20000, `MC_RESP_OKAY, dat[1], 2'b01);
        add_row(OP_IRQ, '0, 32'd1, 1'b1, '0, `MC_RESP_OKAY, 32'd1, 2'b01);
        add_row(OP_IRQ, '0, 32'd0, 1'b1, '0, `MC_RESP_OKAY, 32'd0, 2'b01);
        add_row(OP_IRQ, '0, 32'd1, 1'b1, '0, `MC_RESP_OKAY, 32'd1, 2'b01);
        // Two parity slots flipped leave the data bits intact
        add_row(OP_RD, adr[0], '0, 1'b1, 39'h6, `MC_RESP_ECCERR, dat[0], 2'b11);
        add_row(OP_CLR, '0, '0, 1'b1, '0, `MC_RESP_OKAY, '0, 2'b00);
        add_row(OP_IRQ, '0, 32'd1, 1'b1, '0, `MC_RESP_OKAY, 32'd0, 2'b00);
        add_row(OP_RD, adr[3], '0, 1'b1, 39'h1, `MC_RESP_OKAY, dat[3], 2'b01);
        add_row(OP_CLR, '0, '0, 1'b1, '0, `MC_RESP_OKAY, '0, 2'b00);
        // Data bits 0 and 5 sit at positions 3 and 10
        add_row(OP_RD, adr[2], '0, 1'b1, 39'h408, `MC_RESP_ECCERR, dat[2] ^ 32'h21, 2'b10);
        run_rows();
        finish_test("injected errors");

        add_row(OP_WR, adr[4], dat[4], 1'b0, '0, `MC_RESP_OKAY, '0, 2'b10);
        add_row(OP_RD, adr[4], '0, 1'b0, 39'h10, `MC_RESP_OKAY, dat[4], 2'b10);
        add_row(OP_RD, adr[1], '0, 1'b0, 39'h100, `MC_RESP_OKAY, dat[1], 2'b10);
        add_row(OP_CLR, '0, '0, 1'b1, '0, `MC_RESP_OKAY, '0, 2'b00);
        run_rows();
        finish_test("ecc off");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* mem_ctrl_top.f */
+incdir+include
design/mem_ctrl_pkg.sv
design/mem_ctrl_ifs.sv
design/mem_req_decode.sv
design/ecc_encoder.sv
design/ecc_decoder.sv
design/ecc_status.sv
design/mem_ctrl_top.sv
verif/tb_mem_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f mem_ctrl_top.f --top-module tb_mem_ctrl -o tb_mem_ctrl \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_mem_ctrl > sim.log 2>&1
cat sim.log

grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"
